// File: cp0Subsystem.f
source/cp0Pkg.sv
source/exceptArbiter.sv
source/cp0Regs.sv
source/trapRedirect.sv
source/cp0Top.sv
dv/clockGen.sv
dv/cp0Tb.sv

// File: dv/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    output logic clk,
    output logic rst
);
    localparam int resetCycles = 10;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period.
    end

    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: dv/cp0Tb.sv
`timescale 1ns/1ps

module cp0Tb;
    import cp0Pkg::*;

    localparam int numRandTraps   = 60;
    localparam int cyclesPerTrap  = 3;
    localparam int resetCycles    = 10;
    localparam int directedCycles = 100;
    localparam int cycleLimit =
        2 * (resetCycles + numRandTraps * cyclesPerTrap + directedCycles);

    logic        clk;
    logic        rst;
    logic [5:0]  hwInt;
    excFlags_t   flags;
    logic [31:0] excPc;
    logic [31:0] excBadAddr;
    logic        excBd;
    logic        eret;
    logic        stall;
    logic [7:0]  rdAddr;
    logic        wrEn;
    logic [7:0]  wrAddr;
    logic [31:0] wrData;
    logic [31:0] rdData;
    logic        redirect;
    logic [31:0] redirectPc;

    // Shadow copy of the five registers.
    logic [31:0] modelCount;
    logic        modelHalf;
    logic [7:0]  modelIm;
    logic        modelExl;
    logic        modelIe;
    logic [7:0]  modelIp;
    logic        modelBd;
    logic [4:0]  modelCode;
    logic [31:0] modelEpc;
    logic [31:0] modelBad;
    logic        epcKnown;
    logic        badKnown;
    logic [5:0]  syncA;
    logic [5:0]  syncB;
    logic        expRedirect;
    logic [31:0] expTarget;
    logic [31:0] expRead;
    logic        readKnown;
    logic        swWrite;
    logic        intCond;
    logic        pending;
    logic        takeNow;
    logic        trapNow;
    logic        eretNow;
    logic [4:0]  expCode;
    logic        badWrite;
    logic [31:0] badValue;
    logic [31:0] codeSeen = '0;
    logic        eretSeen = 1'b0;
    logic [31:0] rngState;
    int          cycleCount = 0;
    int          readErrors = 0;
    int          redirectErrors = 0;
    int          targetErrors = 0;
    int          reachErrors = 0;

    clockGen clock_i (.clk(clk), .rst(rst));

    cp0Top dut_i (
        .clk(clk), .rst(rst), .hwInt(hwInt), .flags(flags), .excPc(excPc),
        .excBadAddr(excBadAddr), .excBd(excBd), .eret(eret), .stall(stall),
        .rdAddr(rdAddr), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rdData(rdData), .redirect(redirect), .redirectPc(redirectPc)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [4:0] priorityCode(input logic intr, input excFlags_t f);
        if (intr) return excInt;
        if (f.adelFetch) return excAdel;
        if (f.ri) return excRi;
        if (f.sys) return excSys;
        if (f.bp) return excBp;
        if (f.ov) return excOv;
        if (f.adelData) return excAdel;
        if (f.ades) return excAdes;
        return excInt;
    endfunction

    function automatic logic [7:0] pickAddr(input logic [7:0] sel);
        case (sel % 5)
            0:       return addrBadVAddr;
            1:       return addrCount;
            2:       return addrStatus;
            3:       return addrCause;
            default: return addrEpc;
        endcase
    endfunction

    assign swWrite = wrEn && !stall;

    always_comb begin
        intCond  = modelIe && !modelExl && (|(modelIm & modelIp));
        pending  = intCond || (|flags);
        takeNow  = !stall && (pending || eret);
        trapNow  = takeNow && pending;
        eretNow  = takeNow && !pending;
        expCode  = priorityCode(intCond, flags);
        badWrite = 1'b0;
        badValue = excBadAddr;
        if (intCond) begin
            badWrite = 1'b0;
        end else if (flags.adelFetch) begin
            badWrite = 1'b1;
            badValue = excPc;
        end else if (!(flags.ri || flags.sys || flags.bp || flags.ov)) begin
            badWrite = flags.adelData || flags.ades;
        end
    end

    always_comb begin
        case (rdAddr)
            addrBadVAddr: expRead = modelBad;
            addrCount:    expRead = modelCount;
            addrStatus:   expRead = {9'd0, 1'b1, 6'd0, modelIm, 6'd0, modelExl, modelIe};
            addrCause:    expRead = {modelBd, 15'd0, modelIp, 1'b0, modelCode, 2'd0};
            addrEpc:      expRead = modelEpc;
            default:      expRead = 32'd0;
        endcase
        readKnown = !((rdAddr == addrBadVAddr && !badKnown) || (rdAddr == addrEpc && !epcKnown));
    end

    always @(posedge clk) begin
        if (rst) begin
            modelCount  <= '0;
            modelHalf   <= 1'b0;
            modelIm     <= '0;
            modelExl    <= 1'b0;
            modelIe     <= 1'b0;
            modelIp     <= '0;
            modelBd     <= 1'b0;
            modelCode   <= '0;
            epcKnown    <= 1'b0;
            badKnown    <= 1'b0;
            syncA       <= '0;
            syncB       <= '0;
            expRedirect <= 1'b0;
            expTarget   <= trapVector;
        end else begin
            syncA        <= hwInt;
            syncB        <= syncA;
            modelIp[7:2] <= syncB;
            if (swWrite && wrAddr == addrCount) begin
                modelCount <= wrData;
                modelHalf  <= 1'b0;
            end else begin
                modelHalf <= !modelHalf;
                if (modelHalf) modelCount <= modelCount + 32'd1;
            end
            if (swWrite && wrAddr == addrStatus) begin
                modelIm  <= wrData[15:8];
                modelExl <= wrData[1];
                modelIe  <= wrData[0];
            end
            if (swWrite && wrAddr == addrCause) modelIp[1:0] <= wrData[9:8];
            if (swWrite && wrAddr == addrEpc) begin
                modelEpc <= wrData;
                epcKnown <= 1'b1;
            end
            if (trapNow) begin
                modelExl          <= 1'b1;
                modelBd           <= excBd;
                modelCode         <= expCode;
                modelEpc          <= excPc;  // Trap PC beats a same-cycle write.
                epcKnown          <= 1'b1;
                codeSeen[expCode] <= 1'b1;
                if (badWrite) begin
                    modelBad <= badValue;
                    badKnown <= 1'b1;
                end
            end else if (eretNow) begin
                modelExl <= 1'b0;
                eretSeen <= 1'b1;
            end
            expRedirect <= takeNow;
            if (takeNow) expTarget <= eretNow ? modelEpc : trapVector;
        end
    end

    readMatches: assert property (@(posedge clk) disable iff (rst)
        readKnown |-> rdData == expRead
    ) else begin
        readErrors = readErrors + 1;
        $display("Mismatch at %0t: rdData[%h] got %h expected %h", $time,
                 $sampled(rdAddr), $sampled(rdData), $sampled(expRead));
    end

    redirectMatches: assert property (@(posedge clk) disable iff (rst)
        redirect == expRedirect
    ) else begin
        redirectErrors = redirectErrors + 1;
        $display("Mismatch at %0t: redirect got %b expected %b", $time,
                 $sampled(redirect), $sampled(expRedirect));
    end

    targetMatches: assert property (@(posedge clk) disable iff (rst)
        expRedirect |-> redirectPc == expTarget
    ) else begin
        targetErrors = targetErrors + 1;
        $display("Mismatch at %0t: redirectPc got %h expected %h", $time,
                 $sampled(redirectPc), $sampled(expTarget));
    end

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drawRandom(output logic [31:0] value);
        rngState = xorshift32(rngState);
        value = rngState;
    endtask

    task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
        wrEn   = 1'b1;
        wrAddr = addr;
        wrData = data;
        rdAddr = addr;
        nextCycle();
        wrEn = 1'b0;
        nextCycle();  // Read back.
    endtask

    task automatic readFor(input logic [7:0] addr, input int n);
        rdAddr = addr;
        repeat (n) nextCycle();
    endtask

    task automatic reportCounts();
        $display("Errors: read %0d, redirect %0d, target %0d, unreached %0d",
                 readErrors, redirectErrors, targetErrors, reachErrors);
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: run did not finish within %0d cycles", cycleLimit);
            reportCounts();
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        logic [6:0]  sparse;
        int          i;
        rngState   = 32'd84;
        hwInt      = '0;
        flags      = '0;
        excPc      = '0;
        excBadAddr = '0;
        excBd      = 1'b0;
        eret       = 1'b0;
        stall      = 1'b0;
        rdAddr     = addrStatus;
        wrEn       = 1'b0;
        wrAddr     = '0;
        wrData     = '0;
        @(negedge rst);

        // Reset values and the Count rate.
        readFor(addrStatus, 2);
        readFor(addrCause, 2);
        readFor(addrCount, 9);

        // Software writes, then the same writes under stall.
        writeReg(addrStatus, 32'hFFFF_FFFC);
        writeReg(addrCause, 32'hFFFF_FFFF);
        drawRandom(r1);
        writeReg(addrEpc, r1);
        drawRandom(r1);
        writeReg(addrCount, r1);
        readFor(addrCount, 4);
        stall = 1'b1;
        writeReg(addrStatus, 32'h0000_0003);
        writeReg(addrEpc, 32'h1234_5678);
        writeReg(addrCount, 32'h0000_0010);
        stall = 1'b0;
        writeReg(addrCause, 32'h0);
        writeReg(addrStatus, 32'h0);

        // First seven rounds are one-hot so every code is reached.
        for (i = 0; i < numRandTraps; i++) begin
            drawRandom(r1);
            drawRandom(r2);
            drawRandom(r3);
            sparse     = (i < 7) ? 7'd0 : (r1[6:0] & r2[6:0] & r3[6:0]);
            flags      = excFlags_t'(7'(1 << (i % 7)) | sparse);
            excPc      = r1;
            excBadAddr = r2;
            excBd      = r3[31];
            stall      = (r3[11:8] == 4'd0);
            rdAddr     = pickAddr(r3[23:16]);
            nextCycle();
            flags  = '0;
            stall  = 1'b0;
            rdAddr = pickAddr(r2[23:16]);
            nextCycle();
            rdAddr = pickAddr(r1[23:16]);
            nextCycle();
        end

        // Software interrupt against all seven flags.
        writeReg(addrCause, 32'h0000_0100);
        wrEn   = 1'b1;
        wrAddr = addrStatus;
        wrData = 32'h0000_0101;
        nextCycle();
        wrEn  = 1'b0;
        flags = excFlags_t'(7'h7F);
        excPc = 32'h8000_1000;
        rdAddr = addrCause;
        nextCycle();
        flags = '0;
        readFor(addrCause, 4);  // EXL now blocks the pending interrupt.

        // Hardware lines, first masked out and then masked in.
        writeReg(addrCause, 32'h0);
        writeReg(addrStatus, 32'h0000_0801);
        hwInt = 6'b000001;
        readFor(addrCause, 6);
        hwInt = 6'b000010;
        readFor(addrCause, 3);
        flags.ov = 1'b1;
        excPc    = 32'h8000_2000;
        nextCycle();
        flags = '0;
        hwInt = '0;
        readFor(addrCause, 5);

        // Exception return, then trap against eret.
        drawRandom(r1);
        writeReg(addrEpc, {r1[31:2], 2'b00});
        eret   = 1'b1;
        wrEn   = 1'b1;  // Target stays on the EPC from before this write.
        wrAddr = addrEpc;
        wrData = {~r1[31:2], 2'b00};
        rdAddr = addrStatus;
        nextCycle();
        eret = 1'b0;
        wrEn = 1'b0;
        readFor(addrStatus, 2);
        eret      = 1'b1;
        flags.sys = 1'b1;
        excPc     = 32'h8000_3000;
        nextCycle();
        flags = '0;
        stall = 1'b1;
        nextCycle();
        stall = 1'b0;
        eret  = 1'b0;
        readFor(addrEpc, 2);

        // Trap and EPC write in one cycle.
        wrEn     = 1'b1;
        wrAddr   = addrEpc;
        wrData   = 32'hDEAD_BEE0;
        flags.ov = 1'b1;
        excPc    = 32'h8000_4000;
        rdAddr   = addrEpc;
        nextCycle();
        wrEn  = 1'b0;
        flags = '0;
        readFor(addrEpc, 2);

        for (int c = 0; c < 32; c++) begin
            if (!codeSeen[c] && (c == excInt || c == excAdel || c == excAdes || c == excSys ||
                    c == excBp || c == excRi || c == excOv)) begin
                reachErrors = reachErrors + 1;
                $display("Stimulus never took a trap with exception code %0d", c);
            end
        end
        if (!eretSeen) begin
            reachErrors = reachErrors + 1;
            $display("Stimulus never took an exception return");
        end
        reportCounts();
        if (readErrors + redirectErrors + targetErrors + reachErrors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: runSim.sh
#!/bin/sh
# Builds the CP0 testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module cp0Tb \
    -f cp0Subsystem.f \
    -o cp0Sim

simOut=$(./obj_dir/cp0Sim)
echo "$simOut"

if echo "$simOut" | grep -q "^PASS: all tests$"; then
    exit 0
else
    exit 1
fi

// File: source/cp0Pkg.sv
package cp0Pkg;

    // Register number in [7:3], select in [2:0].
    localparam int regAddrW = 8;

    localparam logic [regAddrW-1:0] addrBadVAddr = {5'd8, 3'd0};
    localparam logic [regAddrW-1:0] addrCount    = {5'd9, 3'd0};
    localparam logic [regAddrW-1:0] addrStatus   = {5'd12, 3'd0};
    localparam logic [regAddrW-1:0] addrCause    = {5'd13, 3'd0};
    localparam logic [regAddrW-1:0] addrEpc      = {5'd14, 3'd0};

    // Cause.ExcCode values.
    localparam logic [4:0] excInt  = 5'd0;
    localparam logic [4:0] excAdel = 5'd4;
    localparam logic [4:0] excAdes = 5'd5;
    localparam logic [4:0] excSys  = 5'd8;
    localparam logic [4:0] excBp   = 5'd9;
    localparam logic [4:0] excRi   = 5'd10;
    localparam logic [4:0] excOv   = 5'd12;

    localparam logic [31:0] trapVector = 32'hBFC0_0380; // Single vector, BEV=1.

    typedef struct packed {
        logic adelFetch;
        logic ri;
        logic sys;
        logic bp;
        logic ov;
        logic adelData;
        logic ades;
    } excFlags_t;

    typedef struct packed {
        logic        take;    // Strobe, qualifies the rest.
        logic        isEret;
        logic [4:0]  code;
        logic        bd;
        logic        badEn;
        logic [31:0] badAddr;
        logic [31:0] epc;
    } trapReq_t;

    typedef struct packed {
        logic [31:0] epc;
        logic        allowInterrupt;
        logic [7:0]  intMask;   // Status IM & Cause IP.
    } cp0State_t;

endpackage

// File: source/cp0Regs.sv
`timescale 1ns/1ps

module cp0Regs (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [5:0]                   syncInt,
    input  logic [cp0Pkg::regAddrW-1:0]  rdAddr,
    input  logic                         wrEn,
    input  logic [cp0Pkg::regAddrW-1:0]  wrAddr,
    input  logic [31:0]                  wrData,
    input  logic                         stall,
    input  cp0Pkg::trapReq_t             req,
    output logic [31:0]                  rdData,
    output cp0Pkg::cp0State_t            state
);
    import cp0Pkg::*;

    logic [31:0] badVAddr;
    logic [32:0] count;     // Bit 0 halves the rate.
    logic [31:0] status;
    logic [31:0] cause;
    logic [31:0] epc;
    logic        swWrite;
    logic        trapTaken;
    logic        eretTaken;

    assign swWrite   = wrEn && !stall;
    assign trapTaken = req.take && !req.isEret;
    assign eretTaken = req.take && req.isEret;

    // ERL=0, EXL=0, IE=1.
    assign state.allowInterrupt = (status[2:0] == 3'b001);
    assign state.intMask        = status[15:8] & cause[15:8];
    assign state.epc            = epc;

    always_comb begin
        case (rdAddr)
            addrBadVAddr: rdData = badVAddr;
            addrCount:    rdData = count[32:1];
            addrStatus:   rdData = status;
            addrCause:    rdData = cause;
            addrEpc:      rdData = epc;
            default:      rdData = 32'd0;
        endcase
    end

    // Count keeps running through a stall.
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (swWrite && wrAddr == addrCount) begin
            count <= {wrData, 1'b0};
        end else begin
            count <= count + 33'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            status     <= '0;
            status[22] <= 1'b1;   // BEV.
        end else begin
            if (swWrite && wrAddr == addrStatus) begin
                status[15:8] <= wrData[15:8];
                status[1:0]  <= wrData[1:0];
            end
            // Trap and eret come after, so they win over a software write.
            if (trapTaken) begin
                status[1] <= 1'b1;
            end else if (eretTaken) begin
                status[1] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cause <= '0;
        end else begin
            cause[15:10] <= syncInt;
            if (swWrite && wrAddr == addrCause) begin
                cause[9:8] <= wrData[9:8];  // Software interrupts.
            end
            if (trapTaken) begin
                cause[31]  <= req.bd;
                cause[6:2] <= req.code;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (trapTaken) begin
            epc <= req.epc;
        end else if (swWrite && wrAddr == addrEpc) begin
            epc <= wrData;
        end
    end

    always_ff @(posedge clk) begin
        if (trapTaken && req.badEn) begin
            badVAddr <= req.badAddr;
        end
    end

    bevStaysSet: assert property (
        @(posedge clk) disable iff (rst)
        status[22]
    ) else $error("cp0Regs: Status.BEV cleared");

endmodule

// File: source/cp0Top.sv
`timescale 1ns/1ps

module cp0Top (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [5:0]                   hwInt,
    input  cp0Pkg::excFlags_t            flags,
    input  logic [31:0]                  excPc,
    input  logic [31:0]                  excBadAddr,
    input  logic                         excBd,
    input  logic                         eret,
    input  logic                         stall,
    input  logic [cp0Pkg::regAddrW-1:0]  rdAddr,
    input  logic                         wrEn,
    input  logic [cp0Pkg::regAddrW-1:0]  wrAddr,
    input  logic [31:0]                  wrData,
    output logic [31:0]                  rdData,
    output logic                         redirect,
    output logic [31:0]                  redirectPc
);
    import cp0Pkg::*;

    logic [5:0] syncInt;
    trapReq_t   req;
    cp0State_t  state;

    exceptArbiter arbiter_i (
        .clk        (clk),
        .rst        (rst),
        .hwInt      (hwInt),
        .flags      (flags),
        .excPc      (excPc),
        .excBadAddr (excBadAddr),
        .excBd      (excBd),
        .eret       (eret),
        .stall      (stall),
        .state      (state),
        .syncInt    (syncInt),
        .req        (req)
    );

    cp0Regs regs_i (
        .clk     (clk),
        .rst     (rst),
        .syncInt (syncInt),
        .rdAddr  (rdAddr),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData),
        .stall   (stall),
        .req     (req),
        .rdData  (rdData),
        .state   (state)
    );

    trapRedirect redirect_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .state      (state),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

endmodule

// File: source/exceptArbiter.sv
`timescale 1ns/1ps

module exceptArbiter (
    input  logic               clk,
    input  logic               rst,
    input  logic [5:0]         hwInt,
    input  cp0Pkg::excFlags_t  flags,
    input  logic [31:0]        excPc,
    input  logic [31:0]        excBadAddr,
    input  logic               excBd,
    input  logic               eret,
    input  logic               stall,
    input  cp0Pkg::cp0State_t  state,
    output logic [5:0]         syncInt,
    output cp0Pkg::trapReq_t   req
);
    import cp0Pkg::*;

    logic [5:0]  hwIntMeta;
    logic        intPending;
    logic        trapPending;
    logic [4:0]  trapCode;
    logic        badEn;
    logic [31:0] badAddr;

    // Two-flop synchronizer for the asynchronous interrupt lines.
    always_ff @(posedge clk) begin
        if (rst) begin
            hwIntMeta <= '0;
            syncInt   <= '0;
        end else begin
            hwIntMeta <= hwInt;
            syncInt   <= hwIntMeta;
        end
    end

    assign intPending  = state.allowInterrupt && (|state.intMask);
    assign trapPending = intPending || (|flags);

    // Fixed priority, interrupt first.
    always_comb begin
        trapCode = excInt;
        badEn    = 1'b0;
        badAddr  = excBadAddr;
        if (intPending) begin
            trapCode = excInt;
        end else if (flags.adelFetch) begin
            trapCode = excAdel;
            badEn    = 1'b1;
            badAddr  = excPc;   // Fetch fault reports the PC itself.
        end else if (flags.ri) begin
            trapCode = excRi;
        end else if (flags.sys) begin
            trapCode = excSys;
        end else if (flags.bp) begin
            trapCode = excBp;
        end else if (flags.ov) begin
            trapCode = excOv;
        end else if (flags.adelData) begin
            trapCode = excAdel;
            badEn    = 1'b1;
        end else if (flags.ades) begin
            trapCode = excAdes;
            badEn    = 1'b1;
        end
    end

    // An eret only goes through when no trap competes with it.
    always_comb begin
        req.take    = !stall && (trapPending || eret);
        req.isEret  = eret && !trapPending;
        req.code    = trapCode;
        req.bd      = excBd;
        req.badEn   = badEn && trapPending;
        req.badAddr = badAddr;
        req.epc     = excPc;
    end

    noTakeInStall: assert property (
        @(posedge clk) disable iff (rst)
        stall |-> !req.take
    ) else $error("exceptArbiter: trap taken while stalled");

endmodule

// File: source/trapRedirect.sv
`timescale 1ns/1ps

module trapRedirect (
    input  logic               clk,
    input  logic               rst,
    input  cp0Pkg::trapReq_t   req,
    input  cp0Pkg::cp0State_t  state,
    output logic               redirect,
    output logic [31:0]        redirectPc
);
    import cp0Pkg::*;

    always_ff @(posedge clk) begin
        if (rst) begin
            redirect <= 1'b0;
        end else begin
            redirect <= req.take;
        end
    end

    // state.epc is sampled on the same edge that overwrites EPC,
    // so an eret returns to the value from before that edge.
    always_ff @(posedge clk) begin
        if (req.take) begin
            redirectPc <= req.isEret ? state.epc : trapVector;
        end
    end

    singleCycleRedirect: assert property (
        @(posedge clk) disable iff (rst)
        redirect |=> !redirect
    ) else $error("trapRedirect: redirect held two cycles");

endmodule
